//--- saturn_pc_core.f
+incdir+testbench
source/saturn_pkg.sv
source/saturn_phase_seq.sv
source/saturn_fetch.sv
source/saturn_jump_decoder.sv
source/saturn_regs_pc_rstk.sv
source/saturn_pc_core.sv
testbench/tb_saturn_pc_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the saturn pc core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f saturn_pc_core.f \
    --top-module tb_saturn_pc_core \
    -o tb_saturn_pc_core

out=$(./obj_dir/tb_saturn_pc_core 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
else
    exit 1
fi

//--- testbench/tb_saturn_programs.svh
//////////////////////////////
// fetch trace programs
//////////////////////////////

`ifndef TB_SATURN_PROGRAMS_SVH
`define TB_SATURN_PROGRAMS_SVH

// one row per run, program number and bus busy mode
// busy mode 0 keeps the bus free, 1 draws it at random
int scen_prog [$] = '{0, 1, 2, 3, 4, 5, 1, 2, 3};
int scen_busy [$] = '{0, 0, 0, 0, 0, 0, 1, 1, 1};

// program nibbles, expected fetch addresses and final stack
task automatic load_program(input int prog);
    saturn_pkg::addr_t     call_addr;
    saturn_pkg::rstk_ptr_t j;
    case (prog)
        // no-op forms 02, 85, 03 step through in order
        0: begin
            place_nibbles(20'h00000, "0285A03B");
            expect_run(20'h00000, 12);
        end
        // GOTO +020, GOLONG -0010, GOVLNG 45678, GOTO -100
        1: begin
            place_nibbles(20'h00000, "6020");
            place_nibbles(20'h00021, "8C0FFF");
            place_nibbles(20'h00013, "8D87654");
            place_nibbles(20'h45678, "600F");
            expect_run(20'h00000, 4);
            expect_run(20'h00021, 6);
            expect_run(20'h00013, 7);
            expect_run(20'h45678, 4);
            expect_run(20'h45579, 3);
        end
        // GOSUB +040, GOSUBL +0100, GOSBVL 12345
        2: begin
            place_nibbles(20'h00000, "7040");
            place_nibbles(20'h00041, "8E0010");
            place_nibbles(20'h00143, "8F54321");
            expect_run(20'h00000, 4);
            expect_run(20'h00041, 6);
            expect_run(20'h00143, 7);
            expect_run(20'h12345, 2);
            exp_ptr      = 3'd2;
            exp_stack[0] = 20'h00004;
            exp_stack[1] = 20'h00047;
            exp_stack[2] = 20'h0014A;
        end
        // two calls, RTN, RTNSXM, then RTN on the empty stack
        3: begin
            place_nibbles(20'h00000, "702001");
            place_nibbles(20'h00021, "8E020000");
            place_nibbles(20'h00043, "01");
            expect_run(20'h00000, 4);
            expect_run(20'h00021, 6);
            expect_run(20'h00043, 2);
            expect_run(20'h00027, 2);
            expect_run(20'h00004, 2);
            expect_run(20'h00000, 2);
            exp_ptr = 3'd6;
        end
        // nine nested GOSUB +00F, ninth push lands on entry 0
        4: begin
            call_addr = '0;
            repeat (9) begin
                place_nibbles(call_addr, "7F00");
                expect_run(call_addr, 4);
                call_addr = call_addr + 20'h10;
            end
            expect_run(20'h00090, 2);
            exp_ptr      = 3'd0;
            exp_stack[0] = 20'h00084;
            j = 3'd1;
            repeat (7) begin
                exp_stack[j] = {13'h0, j, 4'h4};
                j = j + 3'd1;
            end
        end
        // GOTO -002 from address 0 wraps to the top of memory
        default: begin
            place_nibbles(20'h00000, "6EFF");
            expect_run(20'h00000, 4);
            expect_run(20'hFFFFF, 5);
        end
    endcase
endtask

`endif

//--- testbench/tb_saturn_pc_core.sv
//////////////////////////////
// saturn pc core testbench
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module tb_saturn_pc_core;

    localparam int READ_TIMEOUT = 400;

    logic                  i_clk          = 1'b0;
    logic                  i_reset        = 1'b1;
    logic                  i_bus_busy     = 1'b0;
    saturn_pkg::rstk_ptr_t i_dbg_rstk_ptr = 3'd0;
    saturn_pkg::nibble_t   i_bus_nibble;
    saturn_pkg::addr_t     o_bus_addr;
    logic                  o_bus_read;
    saturn_pkg::addr_t     o_dbg_rstk_val;
    saturn_pkg::rstk_ptr_t o_rstk_ptr;

    // nibble memory filled with no-op nibbles
    saturn_pkg::nibble_t   mem [2**20];
    saturn_pkg::addr_t     touched [$];
    saturn_pkg::addr_t     exp_trace [$];
    saturn_pkg::addr_t     exp_stack [saturn_pkg::RSTK_DEPTH];
    saturn_pkg::rstk_ptr_t exp_ptr;
    // 0 free, 1 random, 2 held busy
    int                    busy_ctl = 0;
    int                    seed     = 39;
    int                    busy_draw;

    always #4 i_clk = ~i_clk;

    // memory answers in the same clock
    assign i_bus_nibble = mem[o_bus_addr];

    always @(posedge i_clk) begin
        case (busy_ctl)
            1: begin
                busy_draw = $random(seed);
                i_bus_busy <= busy_draw[0];
            end
            2: i_bus_busy <= 1'b1;
            default: i_bus_busy <= 1'b0;
        endcase
    end

    saturn_pc_core u_dut (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_bus_busy     (i_bus_busy),
        .i_bus_nibble   (i_bus_nibble),
        .i_dbg_rstk_ptr (i_dbg_rstk_ptr),
        .o_bus_addr     (o_bus_addr),
        .o_bus_read     (o_bus_read),
        .o_dbg_rstk_val (o_dbg_rstk_val),
        .o_rstk_ptr     (o_rstk_ptr)
    );

    // xor fold of the address steered off 0, 6, 7 and 8
    function automatic saturn_pkg::nibble_t fill_nibble(input saturn_pkg::addr_t a);
        saturn_pkg::nibble_t f;
        f = a[3:0] ^ a[7:4] ^ a[11:8] ^ a[15:12] ^ a[19:16];
        if (f == 4'h0 || f == 4'h6 || f == 4'h7 || f == 4'h8) begin
            f = f ^ 4'h3;
        end
        return f;
    endfunction

    function automatic saturn_pkg::nibble_t hex_nibble(input byte c);
        byte v;
        v = (c >= "A") ? (c - 8'h37) : (c - 8'h30);
        return v[3:0];
    endfunction

    task automatic place_nibbles(input saturn_pkg::addr_t base, input string hex);
        saturn_pkg::addr_t a;
        a = base;
        for (int i = 0; i < hex.len(); i++) begin
            mem[a] = hex_nibble(hex[i]);
            touched.push_back(a);
            a = a + 20'd1;
        end
    endtask

    // sequential fetches from one address that wrap at 2^20
    task automatic expect_run(input saturn_pkg::addr_t start, input int count);
        saturn_pkg::addr_t a;
        a = start;
        repeat (count) begin
            exp_trace.push_back(a);
            a = a + 20'd1;
        end
    endtask

    `include "tb_saturn_programs.svh"

    task automatic check_addr(input saturn_pkg::addr_t got, input saturn_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %05h expected %05h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "address mismatch");
        end
    endtask

    task automatic check_ptr(input saturn_pkg::rstk_ptr_t got,
                             input saturn_pkg::rstk_ptr_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "pointer mismatch");
        end
    endtask

    task automatic check_read(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s read strobe %0b expected %0b",
                     $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "read strobe mismatch");
        end
    endtask

    // returns on the falling edge where the read strobe is high
    // later reads of a run come on the fourth clock without bus busy
    task automatic wait_for_read(input bit first, input string what);
        int   n;
        int   free_clks;
        logic seen;
        n         = 0;
        free_clks = 0;
        seen      = 1'b0;
        while (!seen && n < READ_TIMEOUT) begin
            @(negedge i_clk);
            n++;
            if (!i_bus_busy) begin
                free_clks++;
            end
            if (!first) begin
                check_read(o_bus_read, !i_bus_busy && (free_clks == 4), what);
            end
            seen = o_bus_read;
        end
        if (!seen) begin
            $display("no fetch read seen within %0d clocks for %s", READ_TIMEOUT, what);
            $display("Simulation FAILED");
            $fatal(1, "fetch timeout");
        end
    endtask

    task automatic apply_reset();
        @(posedge i_clk);
        i_reset <= 1'b1;
        repeat (3) @(posedge i_clk);
        i_reset <= 1'b0;
    endtask

    task automatic run_scenario(input int s, input int prog, input int busy_mode);
        saturn_pkg::rstk_ptr_t p;
        // put back the fill under the previous program
        foreach (touched[t]) begin
            mem[touched[t]] = fill_nibble(touched[t]);
        end
        touched.delete();
        exp_trace.delete();
        exp_ptr   = 3'd7;
        exp_stack = '{default: '0};
        load_program(prog);
        busy_ctl = 0;
        apply_reset();
        @(negedge i_clk);
        busy_ctl = busy_mode;
        for (int k = 0; k < exp_trace.size(); k++) begin
            wait_for_read(k == 0, $sformatf("run %0d fetch %0d", s, k));
            check_addr(o_bus_addr, exp_trace[k], $sformatf("run %0d fetch %0d", s, k));
        end
        // freeze the core before its next decode and read the stack
        busy_ctl = 2;
        check_ptr(o_rstk_ptr, exp_ptr, $sformatf("run %0d stack pointer", s));
        p = 3'd0;
        repeat (saturn_pkg::RSTK_DEPTH) begin
            @(posedge i_clk);
            i_dbg_rstk_ptr <= p;
            @(negedge i_clk);
            check_addr(o_dbg_rstk_val, exp_stack[p],
                       $sformatf("run %0d stack entry %0d", s, p));
            p = p + 3'd1;
        end
    endtask

    initial begin
        saturn_pkg::addr_t fill_addr;
        fill_addr = '0;
        repeat (2**20) begin
            mem[fill_addr] = fill_nibble(fill_addr);
            fill_addr = fill_addr + 20'd1;
        end
        for (int s = 0; s < scen_prog.size(); s++) begin
            run_scenario(s, scen_prog[s], scen_busy[s]);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/saturn_pc_core.sv
//////////////////////////////
// saturn pc front end
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module saturn_pc_core (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_bus_busy,
    input  saturn_pkg::nibble_t    i_bus_nibble,
    input  saturn_pkg::rstk_ptr_t  i_dbg_rstk_ptr,
    output saturn_pkg::addr_t      o_bus_addr,
    output logic                   o_bus_read,
    output saturn_pkg::addr_t      o_dbg_rstk_val,
    output saturn_pkg::rstk_ptr_t  o_rstk_ptr
);

    saturn_pkg::phase_t    phase;
    saturn_pkg::nibble_t   nibble;
    logic                  jump_instr;
    logic                  push_pc;
    logic                  rtn;
    saturn_pkg::jump_len_t jump_length;
    saturn_pkg::jump_len_t operand_idx;
    logic                  init_done;
    saturn_pkg::addr_t     current_pc;

    // sequencer, held until the stack is cleared
    saturn_phase_seq u_phase_seq (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_bus_busy  (i_bus_busy),
        .i_init_done (init_done),
        .o_phase     (phase)
    );

    saturn_fetch u_fetch (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_bus_busy   (i_bus_busy),
        .i_phase      (phase),
        .i_current_pc (current_pc),
        .i_bus_nibble (i_bus_nibble),
        .o_bus_addr   (o_bus_addr),
        .o_bus_read   (o_bus_read),
        .o_nibble     (nibble)
    );

    saturn_jump_decoder u_decoder (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_bus_busy    (i_bus_busy),
        .i_phase       (phase),
        .i_nibble      (nibble),
        .o_jump_instr  (jump_instr),
        .o_push_pc     (push_pc),
        .o_rtn         (rtn),
        .o_jump_length (jump_length),
        .o_operand_idx (operand_idx)
    );

    saturn_regs_pc_rstk u_pc_rstk (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_bus_busy     (i_bus_busy),
        .i_phase        (phase),
        .i_nibble       (nibble),
        .i_jump_instr   (jump_instr),
        .i_push_pc      (push_pc),
        .i_rtn          (rtn),
        .i_jump_length  (jump_length),
        .i_operand_idx  (operand_idx),
        .i_dbg_rstk_ptr (i_dbg_rstk_ptr),
        .o_current_pc   (current_pc),
        .o_init_done    (init_done),
        .o_dbg_rstk_val (o_dbg_rstk_val),
        .o_rstk_ptr     (o_rstk_ptr)
    );

endmodule

`default_nettype wire

//--- source/saturn_regs_pc_rstk.sv
//////////////////////////////
// pc and return stack
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module saturn_regs_pc_rstk (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_bus_busy,
    input  saturn_pkg::phase_t     i_phase,
    input  saturn_pkg::nibble_t    i_nibble,
    input  wire                    i_jump_instr,
    input  wire                    i_push_pc,
    input  wire                    i_rtn,
    input  saturn_pkg::jump_len_t  i_jump_length,
    input  saturn_pkg::jump_len_t  i_operand_idx,
    input  saturn_pkg::rstk_ptr_t  i_dbg_rstk_ptr,
    output saturn_pkg::addr_t      o_current_pc,
    output logic                   o_init_done,
    output saturn_pkg::addr_t      o_dbg_rstk_val,
    output saturn_pkg::rstk_ptr_t  o_rstk_ptr
);

    saturn_pkg::addr_t     pc_q;
    saturn_pkg::rstk_ptr_t rstk_ptr_q;
    saturn_pkg::addr_t     rstk [saturn_pkg::RSTK_DEPTH];

    // clearing after reset
    logic                  init_done_q;
    saturn_pkg::rstk_ptr_t init_cnt_q;

    // operand assembly
    saturn_pkg::addr_t     jump_base_q;
    saturn_pkg::addr_t     offset_q;
    saturn_pkg::addr_t     full_offset;
    saturn_pkg::addr_t     jump_target;

    logic                  inc_step;
    logic                  operand_step;
    logic                  last_operand;
    logic                  do_push;
    logic                  do_pop;
    saturn_pkg::rstk_ptr_t push_ptr;

    // stack write port
    logic                  rstk_we;
    saturn_pkg::rstk_ptr_t rstk_widx;
    saturn_pkg::addr_t     rstk_wdata;

    assign inc_step     = !i_bus_busy && (i_phase == 2'd1);
    assign operand_step = !i_bus_busy && (i_phase == 2'd2) && i_jump_instr;
    assign last_operand = operand_step && (i_operand_idx == (i_jump_length - 3'd1));
    assign do_push      = last_operand && i_push_pc;
    assign do_pop       = !i_bus_busy && (i_phase == 2'd2) && i_rtn;
    assign push_ptr     = rstk_ptr_q + 3'd1;

    // current nibble on top of the collected ones
    // sign extended for the relative forms
    always_comb begin
        case (i_jump_length)
            saturn_pkg::LEN_REL3: full_offset = {{8{i_nibble[3]}}, i_nibble, offset_q[7:0]};
            saturn_pkg::LEN_REL4: full_offset = {{4{i_nibble[3]}}, i_nibble, offset_q[11:0]};
            default:              full_offset = {i_nibble, offset_q[15:0]};
        endcase
    end

    // absolute value for GOVLNG / GOSBVL, base relative otherwise
    // wraps modulo 2^20 by width
    assign jump_target = (i_jump_length == saturn_pkg::LEN_ABS5) ? full_offset
                                                                 : jump_base_q + full_offset;

    // operand nibbles, lsn first
    always_ff @(posedge i_clk) begin
        if (operand_step) begin
            offset_q[{i_operand_idx, 2'b00} +: 4] <= i_nibble;
            // pc already moved past the first offset nibble in phase 1
            if (i_operand_idx == 3'd0) begin
                jump_base_q <= pc_q - 20'd1;
            end
        end
    end

    // control state
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            pc_q        <= saturn_pkg::RESET_PC;
            rstk_ptr_q  <= 3'd7;
            init_done_q <= 1'b0;
            init_cnt_q  <= '0;
        end else begin
            // one entry per clock, then release the sequencer
            if (!init_done_q) begin
                init_cnt_q <= init_cnt_q + 3'd1;
                if (init_cnt_q == saturn_pkg::rstk_ptr_t'(saturn_pkg::RSTK_DEPTH - 1)) begin
                    init_done_q <= 1'b1;
                end
            end

            if (inc_step) begin
                pc_q <= pc_q + 20'd1;
            end else if (last_operand) begin
                pc_q <= jump_target;
            end else if (do_pop) begin
                // empty stack holds 0 here
                pc_q <= rstk[rstk_ptr_q];
            end

            if (do_push) begin
                rstk_ptr_q <= push_ptr;
            end else if (do_pop) begin
                rstk_ptr_q <= rstk_ptr_q - 3'd1;
            end
        end
    end

    // single write port: clear, push or pop-clear, never together
    always_comb begin
        rstk_we    = 1'b0;
        rstk_widx  = rstk_ptr_q;
        rstk_wdata = '0;
        if (!init_done_q) begin
            rstk_we   = 1'b1;
            rstk_widx = init_cnt_q;
        end else if (do_push) begin
            // return address is the nibble after the last operand
            rstk_we    = 1'b1;
            rstk_widx  = push_ptr;
            rstk_wdata = pc_q;
        end else if (do_pop) begin
            rstk_we = 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rstk_we) begin
            rstk[rstk_widx] <= rstk_wdata;
        end
    end

    assign o_current_pc   = pc_q;
    assign o_init_done    = init_done_q;
    // debugger view
    assign o_dbg_rstk_val = rstk[i_dbg_rstk_ptr];
    assign o_rstk_ptr     = rstk_ptr_q;

endmodule

`default_nettype wire

//--- source/saturn_jump_decoder.sv
//////////////////////////////
// control flow decoder
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module saturn_jump_decoder (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_bus_busy,
    input  saturn_pkg::phase_t     i_phase,
    input  saturn_pkg::nibble_t    i_nibble,
    output logic                   o_jump_instr,
    output logic                   o_push_pc,
    output logic                   o_rtn,
    output saturn_pkg::jump_len_t  o_jump_length,
    output saturn_pkg::jump_len_t  o_operand_idx
);

    saturn_pkg::dec_state_t state_q;
    saturn_pkg::jump_len_t  len_q;
    saturn_pkg::jump_len_t  idx_q;
    logic                   push_q;
    logic                   decode_step;
    logic                   last_operand;

    // latched nibble is consumed once per cycle, in phase 2
    assign decode_step = !i_bus_busy && (i_phase == 2'd2);

    assign last_operand = (idx_q == (len_q - 3'd1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= saturn_pkg::DEC_IDLE;
            len_q   <= '0;
            idx_q   <= '0;
            push_q  <= 1'b0;
        end else if (decode_step) begin
            case (state_q)
                saturn_pkg::DEC_IDLE: begin
                    case (i_nibble)
                        // GOTO
                        4'h6: begin
                            state_q <= saturn_pkg::DEC_OPERAND;
                            len_q   <= saturn_pkg::LEN_REL3;
                            idx_q   <= '0;
                            push_q  <= 1'b0;
                        end
                        // GOSUB
                        4'h7: begin
                            state_q <= saturn_pkg::DEC_OPERAND;
                            len_q   <= saturn_pkg::LEN_REL3;
                            idx_q   <= '0;
                            push_q  <= 1'b1;
                        end
                        4'h0: begin
                            state_q <= saturn_pkg::DEC_BLOCK_0;
                        end
                        4'h8: begin
                            state_q <= saturn_pkg::DEC_BLOCK_8;
                        end
                        // everything else is a one nibble no-op
                        default: begin
                            state_q <= saturn_pkg::DEC_IDLE;
                        end
                    endcase
                end

                saturn_pkg::DEC_BLOCK_0: begin
                    // rtn pulse is decoded combinationally below
                    state_q <= saturn_pkg::DEC_IDLE;
                end

                saturn_pkg::DEC_BLOCK_8: begin
                    // C..F only
                    // bit 0 picks absolute (D, F), bit 1 picks call (E, F)
                    if (i_nibble[3:2] == 2'b11) begin
                        state_q <= saturn_pkg::DEC_OPERAND;
                        len_q   <= i_nibble[0] ? saturn_pkg::LEN_ABS5
                                               : saturn_pkg::LEN_REL4;
                        idx_q   <= '0;
                        push_q  <= i_nibble[1];
                    end else begin
                        state_q <= saturn_pkg::DEC_IDLE;
                    end
                end

                saturn_pkg::DEC_OPERAND: begin
                    // count operand nibbles, pc unit uses idx_q this cycle
                    if (last_operand) begin
                        state_q <= saturn_pkg::DEC_IDLE;
                        idx_q   <= '0;
                    end else begin
                        idx_q <= idx_q + 3'd1;
                    end
                end

                default: begin
                    state_q <= saturn_pkg::DEC_IDLE;
                end
            endcase
        end
    end

    // RTNSXM (00) and RTN (01)
    // same clock as the decode so the pc unit pops in phase 2
    assign o_rtn = decode_step
                && (state_q == saturn_pkg::DEC_BLOCK_0)
                && (i_nibble[3:1] == 3'b000);

    // level for the whole operand collection
    assign o_jump_instr  = (state_q == saturn_pkg::DEC_OPERAND);
    assign o_push_pc     = push_q;
    assign o_jump_length = len_q;
    assign o_operand_idx = idx_q;

endmodule

`default_nettype wire

//--- source/saturn_fetch.sv
//////////////////////////////
// nibble fetch stage
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module saturn_fetch (
    input  wire                  i_clk,
    input  wire                  i_reset,
    input  wire                  i_bus_busy,
    input  saturn_pkg::phase_t   i_phase,
    input  saturn_pkg::addr_t    i_current_pc,
    input  saturn_pkg::nibble_t  i_bus_nibble,
    output saturn_pkg::addr_t    o_bus_addr,
    output logic                 o_bus_read,
    output saturn_pkg::nibble_t  o_nibble
);

    saturn_pkg::addr_t   addr_q;
    saturn_pkg::nibble_t nibble_q;

    // address register
    // loaded in phase 3, after any jump or return has settled,
    // and held through phases 0 and 1 for the memory
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            addr_q <= saturn_pkg::RESET_PC;
        end else if (!i_bus_busy && (i_phase == 2'd3)) begin
            addr_q <= i_current_pc;
        end
    end

    // one clock read strobe in phase 0
    // a busy clock keeps the phase, so the strobe waits with it
    assign o_bus_read = (i_phase == 2'd0) && !i_bus_busy;

    // memory answers combinationally, still valid in phase 1
    // holding reg lets decode of this nibble overlap the next fetch
    always_ff @(posedge i_clk) begin
        if (!i_bus_busy && (i_phase == 2'd1)) begin
            nibble_q <= i_bus_nibble;
        end
    end

    assign o_bus_addr = addr_q;
    assign o_nibble   = nibble_q;

endmodule

`default_nettype wire

//--- source/saturn_phase_seq.sv
//////////////////////////////
// nibble phase sequencer
//////////////////////////////

`default_nettype none
`timescale 1ns/1ps

module saturn_phase_seq (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_bus_busy,
    input  wire                 i_init_done,
    output saturn_pkg::phase_t  o_phase
);

    saturn_pkg::phase_t phase_q;

    // phase 0 fetch request
    // phase 1 nibble capture, pc increment
    // phase 2 decode and pc update
    // phase 3 idle, next address set up
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            // parked on 3 so the first step lands on 0
            phase_q <= 2'd3;
        end else if (!i_init_done) begin
            // stack still being cleared
            phase_q <= 2'd3;
        end else if (!i_bus_busy) begin
            // wraps 3 -> 0 on its own
            phase_q <= phase_q + 2'd1;
        end
    end

    assign o_phase = phase_q;

endmodule

`default_nettype wire

//--- source/saturn_pkg.sv
//////////////////////////////
// saturn pc front end types
//////////////////////////////

`default_nettype none

package saturn_pkg;

    // one instruction or operand nibble
    typedef logic [3:0] nibble_t;

    // 20 bit nibble address
    typedef logic [19:0] addr_t;

    // return stack index
    typedef logic [2:0] rstk_ptr_t;

    // position inside the four clock nibble cycle
    typedef logic [1:0] phase_t;

    // operand length and operand position, in nibbles
    typedef logic [2:0] jump_len_t;

    // jump decoder FSM
    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_BLOCK_0,
        DEC_BLOCK_8,
        DEC_OPERAND
    } dec_state_t;

    localparam int RSTK_DEPTH = 8;

    // operand lengths
    // GOTO / GOSUB
    localparam jump_len_t LEN_REL3 = 3'd3;
    // GOLONG / GOSUBL
    localparam jump_len_t LEN_REL4 = 3'd4;
    // GOVLNG / GOSBVL
    localparam jump_len_t LEN_ABS5 = 3'd5;

    localparam addr_t RESET_PC = 20'h00000;

endpackage

`default_nettype wire
